// ==== verilog/busPkg.sv ====
package busPkg;

	//------------------------------
	// Register bus widths
	//------------------------------
	localparam int lpBusAdrsBit   = 32;
	localparam int lpUsiBusWidth  = 32;

	// Block select field sits just above the register offset
	localparam int lpBlockAdrsMap = 4;
	localparam int lpCsrAdrsWidth = 16;

	//------------------------------
	// Block address map
	//------------------------------
	localparam logic [lpBlockAdrsMap-1:0] lpGpioAdrsMap = 4'h1;
	localparam logic [lpBlockAdrsMap-1:0] lpRamAdrsMap  = 4'h6;

	// Register offsets inside a block
	localparam logic [lpCsrAdrsWidth-1:0] lpCsrLed     = 16'h0000;
	localparam logic [lpCsrAdrsWidth-1:0] lpCsrWrCount = 16'h0000;
	localparam logic [lpCsrAdrsWidth-1:0] lpCsrRdCount = 16'h0004;

	localparam int lpLedWidth = 5;

	// Returned when no block answers
	localparam logic [lpUsiBusWidth-1:0] lpCsrMissData = 32'hDEADBEEF;

	// One register request, 65 bits
	typedef struct packed
	{
		logic                     write;
		logic [lpBusAdrsBit-1:0]  adrs;
		logic [lpUsiBusWidth-1:0] wdata;
	} csrReqT;

endpackage

// ==== verilog/memPkg.sv ====
package memPkg;

	//------------------------------
	// On-chip RAM geometry
	//------------------------------
	localparam int lpRamAdrsWidth = 12;
	localparam int lpRamDqWidth   = 8;
	localparam int lpCountWidth   = 16;

	//------------------------------
	// Master IDs
	//------------------------------
	localparam int lpUfiIdNumber = 1;
	localparam logic [lpUfiIdNumber-1:0] lpHostId = 1'b0;
	localparam logic [lpUfiIdNumber-1:0] lpDmaId  = 1'b1;

	// Request toward the RAM, 22 bits
	typedef struct packed
	{
		logic [lpUfiIdNumber-1:0]  id;
		logic                      write;
		logic [lpRamAdrsWidth-1:0] adrs;
		logic [lpRamDqWidth-1:0]   data;
	} memReqT;

	// Read response, ID echoed back for routing
	typedef struct packed
	{
		logic [lpUfiIdNumber-1:0] id;
		logic [lpRamDqWidth-1:0]  rdata;
	} memRspT;

endpackage

// ==== verilog/pipeSlice.sv ====
`timescale 1ns/100ps

module pipeSlice #(
	parameter type payloadT = logic
)(
	input  logic    sysClk,
	input  logic    arstN,
	// Upstream side
	input  logic    inValid,
	input  payloadT inData,
	output logic    inReady,
	// Downstream side
	output logic    outValid,
	output payloadT outData,
	input  logic    outReady
);

// Slot can take a new item when empty or when the held one leaves now
assign inReady = !outValid || outReady;

always_ff @(posedge sysClk or negedge arstN)
begin
	if (!arstN)
		outValid <= 1'b0;
	else if (inReady)
		outValid <= inValid;
end

// Payload only
always_ff @(posedge sysClk)
begin
	if (inReady && inValid)
		outData <= inData;
end

endmodule

// ==== verilog/csrBus.sv ====
`timescale 1ns/100ps

module csrBus import busPkg::*; (
	input  logic                      sysClk,
	input  logic                      arstN,
	// From the register slice
	input  logic                      reqValid,
	input  csrReqT                    req,
	// Block read data, combinational from the offset
	input  logic [lpUsiBusWidth-1:0]  gpioRdata,
	input  logic [lpUsiBusWidth-1:0]  ramRdata,
	// Fan-out to the blocks
	output logic                      gpioWe,
	output logic                      ramWe,
	output logic [lpCsrAdrsWidth-1:0] csrOffset,
	output logic [lpUsiBusWidth-1:0]  csrWdata,
	// Back to the host
	output logic                      csrRdValid,
	output logic [lpUsiBusWidth-1:0]  csrRdata
);

logic [lpBlockAdrsMap-1:0] blockSel;
logic [lpUsiBusWidth-1:0]  rdMux;
logic                      rdReq;

//------------------------------
// Block decode
//------------------------------
assign blockSel  = req.adrs[lpCsrAdrsWidth +: lpBlockAdrsMap];
assign csrOffset = req.adrs[lpCsrAdrsWidth-1:0];
assign csrWdata  = req.wdata;

assign gpioWe = reqValid && req.write && (blockSel == lpGpioAdrsMap);
assign ramWe  = reqValid && req.write && (blockSel == lpRamAdrsMap);
assign rdReq  = reqValid && !req.write;

always_comb
begin
	case (blockSel)
		lpGpioAdrsMap: rdMux = gpioRdata;
		lpRamAdrsMap:  rdMux = ramRdata;
		// Nobody mapped here
		default:       rdMux = lpCsrMissData;
	endcase
end

//------------------------------
// Read return, one cycle later
//------------------------------
always_ff @(posedge sysClk or negedge arstN)
begin
	if (!arstN)
		csrRdValid <= 1'b0;
	else
		csrRdValid <= rdReq;
end

always_ff @(posedge sysClk)
begin
	if (rdReq)
		csrRdata <= rdMux;
end

endmodule

// ==== verilog/gpioBlock.sv ====
`timescale 1ns/100ps

module gpioBlock import busPkg::*; (
	input  logic                      sysClk,
	input  logic                      arstN,
	input  logic                      we,
	input  logic [lpCsrAdrsWidth-1:0] csrOffset,
	input  logic [lpUsiBusWidth-1:0]  csrWdata,
	output logic [lpUsiBusWidth-1:0]  rdata,
	// LED pins
	output logic [1:0]                led,
	output logic                      ledB,
	output logic                      ledG,
	output logic                      ledR
);

logic [lpLedWidth-1:0] ledReg;

always_ff @(posedge sysClk or negedge arstN)
begin
	if (!arstN)
		ledReg <= '0;
	else if (we && (csrOffset == lpCsrLed))
		ledReg <= csrWdata[lpLedWidth-1:0];
end

// Readback, other offsets give zero
assign rdata = (csrOffset == lpCsrLed) ?
	{{(lpUsiBusWidth-lpLedWidth){1'b0}}, ledReg} : '0;

// Bits 1:0 plain LEDs, then blue, green, red
assign led  = ledReg[1:0];
assign ledB = ledReg[2];
assign ledG = ledReg[3];
assign ledR = ledReg[4];

endmodule

// ==== verilog/memArbiter.sv ====
`timescale 1ns/100ps

module memArbiter import memPkg::*; (
	input  logic                      sysClk,
	input  logic                      arstN,
	// Host memory port
	input  logic                      memHostValid,
	output logic                      memHostReady,
	input  logic                      memHostWrite,
	input  logic [lpRamAdrsWidth-1:0] memHostAdrs,
	input  logic [lpRamDqWidth-1:0]   memHostWdata,
	output logic                      memHostRdValid,
	output logic [lpRamDqWidth-1:0]   memHostRdata,
	// DMA memory port
	input  logic                      memDmaValid,
	output logic                      memDmaReady,
	input  logic                      memDmaWrite,
	input  logic [lpRamAdrsWidth-1:0] memDmaAdrs,
	input  logic [lpRamDqWidth-1:0]   memDmaWdata,
	output logic                      memDmaRdValid,
	output logic [lpRamDqWidth-1:0]   memDmaRdata,
	// Toward the RAM
	output logic                      reqValid,
	output memReqT                    req,
	input  logic                      reqReady,
	input  logic                      rspValid,
	input  memRspT                    rsp
);

logic   lastDma;
logic   pickDma;
logic   pickHost;
logic   anyValid;
logic   sliceReady;
memReqT winReq;

//------------------------------
// Round-robin grant
//------------------------------
// DMA wins alone, or on a tie when the host had the last turn
assign anyValid = memHostValid || memDmaValid;
assign pickDma  = memDmaValid && (!memHostValid || !lastDma);
assign pickHost = memHostValid && !pickDma;

assign memHostReady = pickHost && sliceReady;
assign memDmaReady  = pickDma && sliceReady;

always_ff @(posedge sysClk or negedge arstN)
begin
	if (!arstN)
		lastDma <= 1'b0;
	else if (anyValid && sliceReady)
		lastDma <= pickDma;
end

// Stamp the winner's ID
assign winReq = pickDma ?
	'{id: lpDmaId, write: memDmaWrite, adrs: memDmaAdrs, data: memDmaWdata} :
	'{id: lpHostId, write: memHostWrite, adrs: memHostAdrs, data: memHostWdata};

pipeSlice #(
	.payloadT (memReqT)
) reqSlice_i (
	.sysClk   (sysClk),
	.arstN    (arstN),
	.inValid  (anyValid),
	.inData   (winReq),
	.inReady  (sliceReady),
	.outValid (reqValid),
	.outData  (req),
	.outReady (reqReady)
);

//------------------------------
// Response steering by ID
//------------------------------
assign memHostRdValid = rspValid && (rsp.id == lpHostId);
assign memDmaRdValid  = rspValid && (rsp.id == lpDmaId);
assign memHostRdata   = rsp.rdata;
assign memDmaRdata    = rsp.rdata;

endmodule

// ==== verilog/sramBlock.sv ====
`timescale 1ns/100ps

module sramBlock import busPkg::*, memPkg::*; (
	input  logic                      sysClk,
	input  logic                      arstN,
	// Memory request side
	input  logic                      reqValid,
	input  memReqT                    req,
	output logic                      reqReady,
	output logic                      rspValid,
	output memRspT                    rsp,
	// Control registers
	input  logic                      we,
	input  logic [lpCsrAdrsWidth-1:0] csrOffset,
	input  logic [lpUsiBusWidth-1:0]  csrWdata,
	output logic [lpUsiBusWidth-1:0]  rdata
);

logic [lpRamDqWidth-1:0]  ram [0:(1<<lpRamAdrsWidth)-1];
logic [lpCountWidth-1:0]  wrCount;
logic [lpCountWidth-1:0]  rdCount;
logic                     accept;
logic                     clrWr;
logic                     clrRd;

// Single-port array takes one request every cycle
assign reqReady = 1'b1;
assign accept   = reqValid && reqReady;

//------------------------------
// Byte array, one-cycle read
//------------------------------
always_ff @(posedge sysClk)
begin
	if (accept)
	begin
		if (req.write)
			ram[req.adrs] <= req.data;
		else
			rsp <= '{id: req.id, rdata: ram[req.adrs]};
	end
end

always_ff @(posedge sysClk or negedge arstN)
begin
	if (!arstN)
		rspValid <= 1'b0;
	else
		rspValid <= accept && !req.write;
end

//------------------------------
// Transaction counters
//------------------------------
// Register write clears, the written value is not stored
assign clrWr = we && (csrOffset == lpCsrWrCount);
assign clrRd = we && (csrOffset == lpCsrRdCount);

always_ff @(posedge sysClk or negedge arstN)
begin
	if (!arstN)
	begin
		wrCount <= '0;
		rdCount <= '0;
	end
	else
	begin
		// Saturate at all ones
		if (clrWr)
			wrCount <= '0;
		else if (accept && req.write && (wrCount != '1))
			wrCount <= wrCount + 1'b1;
		if (clrRd)
			rdCount <= '0;
		else if (accept && !req.write && (rdCount != '1))
			rdCount <= rdCount + 1'b1;
	end
end

always_comb
begin
	case (csrOffset)
		lpCsrWrCount: rdata = {{(lpUsiBusWidth-lpCountWidth){1'b0}}, wrCount};
		lpCsrRdCount: rdata = {{(lpUsiBusWidth-lpCountWidth){1'b0}}, rdCount};
		default:      rdata = '0;
	endcase
end

endmodule

// ==== verilog/processor.sv ====
`timescale 1ns/100ps

module processor import busPkg::*, memPkg::*; (
	input  logic                      sysClk,
	input  logic                      arstN,
	// Register host port
	input  logic                      csrValid,
	output logic                      csrReady,
	input  logic                      csrWrite,
	input  logic [lpBusAdrsBit-1:0]   csrAdrs,
	input  logic [lpUsiBusWidth-1:0]  csrWdata,
	output logic                      csrRdValid,
	output logic [lpUsiBusWidth-1:0]  csrRdata,
	// Host memory port
	input  logic                      memHostValid,
	output logic                      memHostReady,
	input  logic                      memHostWrite,
	input  logic [lpRamAdrsWidth-1:0] memHostAdrs,
	input  logic [lpRamDqWidth-1:0]   memHostWdata,
	output logic                      memHostRdValid,
	output logic [lpRamDqWidth-1:0]   memHostRdata,
	// DMA memory port
	input  logic                      memDmaValid,
	output logic                      memDmaReady,
	input  logic                      memDmaWrite,
	input  logic [lpRamAdrsWidth-1:0] memDmaAdrs,
	input  logic [lpRamDqWidth-1:0]   memDmaWdata,
	output logic                      memDmaRdValid,
	output logic [lpRamDqWidth-1:0]   memDmaRdata,
	// LED pins
	output logic [1:0]                led,
	output logic                      ledB,
	output logic                      ledG,
	output logic                      ledR
);

csrReqT                    hostReq;
csrReqT                    csrReq;
logic                      csrReqValid;
logic                      gpioWe;
logic                      ramWe;
logic [lpCsrAdrsWidth-1:0] blkOffset;
logic [lpUsiBusWidth-1:0]  blkWdata;
logic [lpUsiBusWidth-1:0]  gpioRdata;
logic [lpUsiBusWidth-1:0]  ramRdata;
logic                      ramReqValid;
memReqT                    ramReq;
logic                      ramReqReady;
logic                      ramRspValid;
memRspT                    ramRsp;

//------------------------------
// Register bus
//------------------------------
assign hostReq = '{write: csrWrite, adrs: csrAdrs, wdata: csrWdata};

// csrBus never stalls, so the slice drains every cycle
pipeSlice #(.payloadT(csrReqT)) csrSlice_i (
	.sysClk(sysClk), .arstN(arstN),
	.inValid(csrValid), .inData(hostReq), .inReady(csrReady),
	.outValid(csrReqValid), .outData(csrReq), .outReady(1'b1)
);

csrBus csrBus_i (
	.sysClk(sysClk), .arstN(arstN),
	.reqValid(csrReqValid), .req(csrReq),
	.gpioRdata(gpioRdata), .ramRdata(ramRdata),
	.gpioWe(gpioWe), .ramWe(ramWe),
	.csrOffset(blkOffset), .csrWdata(blkWdata),
	.csrRdValid(csrRdValid), .csrRdata(csrRdata)
);

gpioBlock gpio_i (
	.sysClk(sysClk), .arstN(arstN),
	.we(gpioWe), .csrOffset(blkOffset), .csrWdata(blkWdata), .rdata(gpioRdata),
	.led(led), .ledB(ledB), .ledG(ledG), .ledR(ledR)
);

//------------------------------
// Memory fabric
//------------------------------
memArbiter arbiter_i (
	.sysClk(sysClk), .arstN(arstN),
	.memHostValid(memHostValid), .memHostReady(memHostReady),
	.memHostWrite(memHostWrite), .memHostAdrs(memHostAdrs),
	.memHostWdata(memHostWdata),
	.memHostRdValid(memHostRdValid), .memHostRdata(memHostRdata),
	.memDmaValid(memDmaValid), .memDmaReady(memDmaReady),
	.memDmaWrite(memDmaWrite), .memDmaAdrs(memDmaAdrs),
	.memDmaWdata(memDmaWdata),
	.memDmaRdValid(memDmaRdValid), .memDmaRdata(memDmaRdata),
	.reqValid(ramReqValid), .req(ramReq), .reqReady(ramReqReady),
	.rspValid(ramRspValid), .rsp(ramRsp)
);

sramBlock sram_i (
	.sysClk(sysClk), .arstN(arstN),
	.reqValid(ramReqValid), .req(ramReq), .reqReady(ramReqReady),
	.rspValid(ramRspValid), .rsp(ramRsp),
	.we(ramWe), .csrOffset(blkOffset), .csrWdata(blkWdata), .rdata(ramRdata)
);

endmodule

// ==== bench/tbClock.sv ====
`timescale 1ns/100ps

module tbClock (
	output logic sysClk,
	output logic arstN
);

// 100 ns period
initial
begin
	sysClk = 1'b0;
	forever
		#50 sysClk = !sysClk;
end

// Reset held over the first two rising edges, released at drive time
initial
begin
	arstN = 1'b0;
	repeat (2)
		@(posedge sysClk);
	#10;
	arstN = 1'b1;
end

endmodule

// ==== bench/processorBind_sva.sv ====
`timescale 1ns/100ps

module busProtocolChecks import memPkg::*; (
	input logic                      sysClk,
	input logic                      arstN,
	input logic                      csrValid,
	input logic                      csrReady,
	input logic                      csrWrite,
	input logic                      csrRdValid,
	input logic                      memHostValid,
	input logic                      memHostReady,
	input logic                      memHostWrite,
	input logic [lpRamAdrsWidth-1:0] memHostAdrs,
	input logic [lpRamDqWidth-1:0]   memHostWdata,
	input logic                      memHostRdValid,
	input logic                      memDmaValid,
	input logic                      memDmaReady,
	input logic                      memDmaWrite,
	input logic [lpRamAdrsWidth-1:0] memDmaAdrs,
	input logic [lpRamDqWidth-1:0]   memDmaWdata,
	input logic                      memDmaRdValid
);

// Which port won the last memory handshake
logic lastGrantDma;

always_ff @(posedge sysClk or negedge arstN)
begin
	if (!arstN)
		lastGrantDma <= 1'b0;
	else if (memDmaValid && memDmaReady)
		lastGrantDma <= 1'b1;
	else if (memHostValid && memHostReady)
		lastGrantDma <= 1'b0;
end

//------------------------------
// Arbitration
//------------------------------
roundRobin: assert property (@(posedge sysClk) disable iff (!arstN)
	memHostValid && memDmaValid |->
		(memDmaReady != lastGrantDma) && (memHostReady == lastGrantDma))
	else $error("tie between both memory ports went to the last winner");

loneRequest: assert property (@(posedge sysClk) disable iff (!arstN)
	memHostValid != memDmaValid |->
		(memHostReady == memHostValid) && (memDmaReady == memDmaValid))
	else $error("single requesting memory port was not granted");

//------------------------------
// Read latency
//------------------------------
hostReadLatency: assert property (@(posedge sysClk) disable iff (!arstN)
	memHostValid && memHostReady && !memHostWrite |-> ##2 memHostRdValid)
	else $error("host read response missing two cycles after handshake");

dmaReadLatency: assert property (@(posedge sysClk) disable iff (!arstN)
	memDmaValid && memDmaReady && !memDmaWrite |-> ##2 memDmaRdValid)
	else $error("DMA read response missing two cycles after handshake");

csrReadLatency: assert property (@(posedge sysClk) disable iff (!arstN)
	csrValid && csrReady && !csrWrite |-> ##2 csrRdValid)
	else $error("register read data missing two cycles after handshake");

// Waiting masters keep their request
hostHold: assert property (@(posedge sysClk) disable iff (!arstN)
	memHostValid && !memHostReady |=>
		memHostValid && $stable({memHostWrite, memHostAdrs, memHostWdata}))
	else $error("host request changed while waiting");

dmaHold: assert property (@(posedge sysClk) disable iff (!arstN)
	memDmaValid && !memDmaReady |=>
		memDmaValid && $stable({memDmaWrite, memDmaAdrs, memDmaWdata}))
	else $error("DMA request changed while waiting");

endmodule

bind processor busProtocolChecks checks_i (
	.sysClk(sysClk), .arstN(arstN),
	.csrValid(csrValid), .csrReady(csrReady), .csrWrite(csrWrite), .csrRdValid(csrRdValid),
	.memHostValid(memHostValid), .memHostReady(memHostReady), .memHostWrite(memHostWrite),
	.memHostAdrs(memHostAdrs), .memHostWdata(memHostWdata), .memHostRdValid(memHostRdValid),
	.memDmaValid(memDmaValid), .memDmaReady(memDmaReady), .memDmaWrite(memDmaWrite),
	.memDmaAdrs(memDmaAdrs), .memDmaWdata(memDmaWdata), .memDmaRdValid(memDmaRdValid)
);

// ==== bench/processorTb.sv ====
`timescale 1ns/100ps

module processorTb import busPkg::*, memPkg::*; ();

// Cycle budgets of tests 1 to 6, summed
localparam int lpBudgetCycles = 10 + 20 + 15 + 120 + 60 + 60;

logic                      sysClk;
logic                      arstN;
logic                      csrValid;
logic                      csrReady;
logic                      csrWrite;
logic [lpBusAdrsBit-1:0]   csrAdrs;
logic [lpUsiBusWidth-1:0]  csrWdata;
logic                      csrRdValid;
logic [lpUsiBusWidth-1:0]  csrRdata;
logic                      memHostValid;
logic                      memHostReady;
logic                      memHostWrite;
logic [lpRamAdrsWidth-1:0] memHostAdrs;
logic [lpRamDqWidth-1:0]   memHostWdata;
logic                      memHostRdValid;
logic [lpRamDqWidth-1:0]   memHostRdata;
logic                      memDmaValid;
logic                      memDmaReady;
logic                      memDmaWrite;
logic [lpRamAdrsWidth-1:0] memDmaAdrs;
logic [lpRamDqWidth-1:0]   memDmaWdata;
logic                      memDmaRdValid;
logic [lpRamDqWidth-1:0]   memDmaRdata;
logic [1:0]                led;
logic                      ledB;
logic                      ledG;
logic                      ledR;

// Expected RAM contents and what came back
logic [7:0] ramModel [0:(1<<lpRamAdrsWidth)-1];
logic [7:0] hostRsp [$];
logic [7:0] dmaRsp [$];
bit         grantLog [$];
int         errCount;
int         testErrs;
int         passCount;
int         failCount;

tbClock clock_i (.sysClk(sysClk), .arstN(arstN));

processor dut_i (.*);

// Mid-cycle sampling, all outputs settled
always @(negedge sysClk)
begin
	if (memHostRdValid)
		hostRsp.push_back(memHostRdata);
	if (memDmaRdValid)
		dmaRsp.push_back(memDmaRdata);
	if (memHostValid && memHostReady)
		grantLog.push_back(1'b0);
	if (memDmaValid && memDmaReady)
		grantLog.push_back(1'b1);
end

task automatic nextDrive();
	@(posedge sysClk);
	#10;
endtask

task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
	assert (got === exp)
	else
	begin
		$display("error %s got 0x%h expected 0x%h", name, got, exp);
		errCount++;
	end
endtask

task automatic csrAccess(bit write, logic [31:0] adrs, logic [31:0] data);
	bit hs;
	csrValid = 1'b1;
	csrWrite = write;
	csrAdrs  = adrs;
	csrWdata = data;
	hs = 1'b0;
	while (!hs)
	begin
		@(negedge sysClk);
		hs = csrReady;
		nextDrive();
	end
	csrValid = 1'b0;
endtask

task automatic csrRead(logic [31:0] adrs, output logic [31:0] data);
	int tries;
	tries = 0;
	csrAccess(1'b0, adrs, '0);
	while (!csrRdValid && tries < 6)
	begin
		nextDrive();
		tries++;
	end
	assert (csrRdValid)
	else
	begin
		$display("register read at 0x%h never returned data", adrs);
		errCount++;
	end
	data = csrRdata;
endtask

// One memory request, held until the port is granted
task automatic memRequest(bit dma, bit write, logic [31:0] adrs, logic [31:0] data);
	bit hs;
	if (dma)
	begin
		memDmaValid = 1'b1;
		memDmaWrite = write;
		memDmaAdrs  = adrs[lpRamAdrsWidth-1:0];
		memDmaWdata = data[lpRamDqWidth-1:0];
	end
	else
	begin
		memHostValid = 1'b1;
		memHostWrite = write;
		memHostAdrs  = adrs[lpRamAdrsWidth-1:0];
		memHostWdata = data[lpRamDqWidth-1:0];
	end
	hs = 1'b0;
	while (!hs)
	begin
		@(negedge sysClk);
		hs = dma ? memDmaReady : memHostReady;
		nextDrive();
	end
	if (write)
		ramModel[adrs[lpRamAdrsWidth-1:0]] = data[lpRamDqWidth-1:0];
	if (dma)
		memDmaValid = 1'b0;
	else
		memHostValid = 1'b0;
endtask

task automatic writeRandom(bit dma, int count, output logic [31:0] adrsList [$]);
	logic [31:0] rnd;
	for (int i = 0; i < count; i++)
	begin
		rnd = $urandom();
		adrsList.push_back({20'h0, rnd[lpRamAdrsWidth-1:0]});
		memRequest(dma, 1'b1, adrsList[i], $urandom());
	end
endtask

task automatic readList(bit dma, logic [31:0] adrsList [$]);
	foreach (adrsList[i])
		memRequest(dma, 1'b0, adrsList[i], 32'h0);
endtask

task automatic waitResponses(int hostN, int dmaN);
	int tries;
	tries = 0;
	while ((hostRsp.size() < hostN || dmaRsp.size() < dmaN) && tries < 10)
	begin
		nextDrive();
		tries++;
	end
	// One more cycle so a surplus response shows up
	nextDrive();
	assert (hostRsp.size() == hostN && dmaRsp.size() == dmaN)
	else
	begin
		$display("expected %0d host and %0d DMA read responses but saw %0d and %0d",
			hostN, dmaN, hostRsp.size(), dmaRsp.size());
		errCount++;
	end
endtask

task automatic checkReads(string name, logic [7:0] got [$], logic [31:0] adrsList [$]);
	for (int i = 0; i < got.size() && i < adrsList.size(); i++)
		checkValue(name, {24'h0, got[i]},
			{24'h0, ramModel[adrsList[i][lpRamAdrsWidth-1:0]]});
endtask

task automatic finishTest(int num, string name);
	if (errCount == testErrs)
	begin
		passCount++;
		$display("test %0d %s: ok", num, name);
	end
	else
	begin
		failCount++;
		$display("test %0d %s: fail with %0d errors", num, name, errCount - testErrs);
	end
	testErrs = errCount;
endtask

initial
begin : testSequence
	logic [31:0] rnd;
	logic [31:0] val;
	logic [31:0] rdata;
	logic [31:0] hostAdrs [$];
	logic [31:0] dmaAdrs [$];
	int          nWr;
	bit          alternates;

	void'($urandom(13379));
	csrValid     = 1'b0;
	csrWrite     = 1'b0;
	csrAdrs      = '0;
	csrWdata     = '0;
	memHostValid = 1'b0;
	memHostWrite = 1'b0;
	memHostAdrs  = '0;
	memHostWdata = '0;
	memDmaValid  = 1'b0;
	memDmaWrite  = 1'b0;
	memDmaAdrs   = '0;
	memDmaWdata  = '0;
	errCount  = 0;
	testErrs  = 0;
	passCount = 0;
	failCount = 0;
	wait (arstN);

	//------------------------------
	// 1 to 3, register bus
	//------------------------------
	checkValue("led pins", {27'h0, ledR, ledG, ledB, led}, 32'h0);
	checkValue("csrRdValid", {31'h0, csrRdValid}, 32'h0);
	checkValue("memHostRdValid", {31'h0, memHostRdValid}, 32'h0);
	checkValue("memDmaRdValid", {31'h0, memDmaRdValid}, 32'h0);
	checkValue("csrReady", {31'h0, csrReady}, 32'h1);
	finishTest(1, "reset state");

	rnd = $urandom();
	val = $urandom();
	csrAccess(1'b1, {rnd[31:20], lpGpioAdrsMap, lpCsrLed}, val);
	nextDrive();
	checkValue("led pins", {27'h0, ledR, ledG, ledB, led}, {27'h0, val[4:0]});
	csrRead({rnd[31:20], lpGpioAdrsMap, lpCsrLed}, rdata);
	checkValue("csrRdata", rdata, {27'h0, val[4:0]});
	finishTest(2, "LED write and readback");

	do
	begin
		rnd = $urandom();
	end
	while (rnd[19:16] == lpGpioAdrsMap || rnd[19:16] == lpRamAdrsMap);
	csrRead(rnd, rdata);
	checkValue("csrRdata", rdata, lpCsrMissData);
	finishTest(3, "unmapped block");

	//------------------------------
	// 4 to 6, memory fabric
	//------------------------------
	writeRandom(1'b0, 8, hostAdrs);
	hostRsp.delete();
	dmaRsp.delete();
	readList(1'b1, hostAdrs);
	waitResponses(0, 8);
	checkReads("memDmaRdata", dmaRsp, hostAdrs);
	writeRandom(1'b1, 8, dmaAdrs);
	hostRsp.delete();
	dmaRsp.delete();
	readList(1'b0, dmaAdrs);
	waitResponses(8, 0);
	checkReads("memHostRdata", hostRsp, dmaAdrs);
	finishTest(4, "host and DMA copy");

	// Both ports keep valid high the whole time
	hostRsp.delete();
	dmaRsp.delete();
	grantLog.delete();
	fork
		readList(1'b0, hostAdrs);
		readList(1'b1, dmaAdrs);
	join
	waitResponses(8, 8);
	alternates = (grantLog.size() == 16);
	for (int i = 1; i < grantLog.size(); i++)
		if (grantLog[i] == grantLog[i-1])
			alternates = 1'b0;
	assert (alternates)
	else
	begin
		$display("grants did not alternate between the host and DMA ports");
		errCount++;
	end
	checkReads("memHostRdata", hostRsp, hostAdrs);
	checkReads("memDmaRdata", dmaRsp, dmaAdrs);
	finishTest(5, "contention");

	csrAccess(1'b1, {12'h0, lpRamAdrsMap, lpCsrWrCount}, $urandom());
	csrAccess(1'b1, {12'h0, lpRamAdrsMap, lpCsrRdCount}, $urandom());
	nWr = $urandom_range(5, 2);
	hostAdrs.delete();
	writeRandom(1'b0, nWr, hostAdrs);
	hostRsp.delete();
	dmaRsp.delete();
	fork
		readList(1'b0, hostAdrs);
		readList(1'b1, hostAdrs);
	join
	waitResponses(nWr, nWr);
	csrRead({12'h0, lpRamAdrsMap, lpCsrWrCount}, rdata);
	checkValue("csrRdata write counter", rdata, nWr);
	csrRead({12'h0, lpRamAdrsMap, lpCsrRdCount}, rdata);
	checkValue("csrRdata read counter", rdata, 2 * nWr);
	finishTest(6, "transaction counters");

	$display("%0d tests ok, %0d tests failed, %0d errors", passCount, failCount, errCount);
	if (errCount == 0)
		$display("TESTBENCH PASSED");
	else
		$display("TESTBENCH FAILED");
	$finish;
end

// Twice the summed budgets
initial
begin
	#(lpBudgetCycles * 100 * 2);
	$display("watchdog expired before the tests finished");
	$display("TESTBENCH FAILED");
	$finish;
end

endmodule

// ==== list.f ====
verilog/busPkg.sv
verilog/memPkg.sv
verilog/pipeSlice.sv
verilog/csrBus.sv
verilog/gpioBlock.sv
verilog/memArbiter.sv
verilog/sramBlock.sv
verilog/processor.sv
bench/tbClock.sv
bench/processorBind_sva.sv
bench/processorTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the processor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module processorTb -Mdir obj_dir -f list.f

# The simulation may stop early on an assertion, the grep decides
out=$(./obj_dir/VprocessorTb) || true
echo "$out"
if grep -qx "TESTBENCH PASSED" <<< "$out"; then
	exit 0
fi
exit 1
